//--- ftb_top.f
src/ftb_pkg.sv
src/ftb_sram_set.sv
src/ftb_random_rep.sv
src/ftb_sram.sv
src/ftb_update_ctrl.sv
src/ftb_top.sv
sim/ftb_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the FTB testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f ftb_top.f --top-module ftb_top_tb -o ftb_top_tb_sim
./obj_dir/ftb_top_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

//--- sim/ftb_top_tb.sv
`timescale 1ns/1ps

module ftb_top_tb
    import ftb_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [15:0] LFSR_SEED      = 16'd5868;

    logic             clk;
    logic             rst;
    logic             i_squash;
    logic             i_lookup_vld;
    ftb_lookup_req_t  i_lookup;
    logic             o_lookup_gnt;
    logic             o_resp_vld;
    ftb_lookup_resp_t o_resp;
    logic             i_update_vld;
    ftb_update_req_t  i_update;

    int          cycle_count = 0;
    int          value_errs;
    int          other_errs;
    logic [15:0] lfsr_q;

    // reference model, ways filled in order per set
    pc_t       ref_pc   [FTB_SETS][FTB_WAYS];
    ftb_info_t ref_info [FTB_SETS][FTB_WAYS];
    int        ref_cnt  [FTB_SETS];

    // the set under test and its five tags
    ftb_index_t fill_set;
    pc_t        set_pcs   [5];
    ftb_info_t  set_infos [5];

    ftb_top ftb_top_i (
        .clk          (clk),
        .rst          (rst),
        .i_squash     (i_squash),
        .i_lookup_vld (i_lookup_vld),
        .i_lookup     (i_lookup),
        .o_lookup_gnt (o_lookup_gnt),
        .o_resp_vld   (o_resp_vld),
        .o_resp       (o_resp),
        .i_update_vld (i_update_vld),
        .i_update     (i_update)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // hit vector must be one-hot or empty
    always @(negedge clk) begin
        if (!rst) begin
            assert ($onehot0(ftb_top_i.u_sram.s1_hit_vec)) else begin
                other_errs++;
                $display("%0t: more than one way hit in the same set", $time);
            end
        end
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        // taps 16,15,13,4
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[15]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic rand_info(output ftb_info_t info);
        logic [31:0] t;
        rand_bits(32, t);
        info.target_pc = t;
        rand_bits(2, t);
        info.br_type = t[1:0];
        rand_bits(4, t);
        info.fall_offset = t[3:0];
    endtask

    // index in bits 5:1, tag in bits 21:6
    task automatic rand_pc(input ftb_index_t idx, input ftb_tag_t tag, output pc_t pc);
        logic [31:0] t;
        rand_bits(10, t);
        pc = {t[9:0], tag, idx, 1'b0};
    endtask

    task automatic new_tag(input int n_used, output ftb_tag_t tag);
        logic [31:0] t;
        logic        dup;
        dup = 1'b1;
        while (dup) begin
            rand_bits(16, t);
            tag = t[15:0];
            dup = 1'b0;
            for (int j = 0; j < n_used; j++) begin
                if (set_pcs[j][21:6] == tag) dup = 1'b1;
            end
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        assert (got === exp) else begin
            value_errs++;
            $display("[ERROR] %0t %s exp %0b got %0b", $time, name, exp, got);
        end
    endtask

    task automatic check_info(input string name, input ftb_info_t exp, input ftb_info_t got);
        assert (got === exp) else begin
            value_errs++;
            $display("[ERROR] %0t %s exp %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic model_find(input pc_t pc, output int way);
        ftb_index_t idx;
        idx = pc[5:1];
        way = -1;
        for (int w = 0; w < ref_cnt[idx]; w++) begin
            if (ref_pc[idx][w][21:6] == pc[21:6]) way = w;
        end
    endtask

    // a full set with a new tag is left to model_replace
    task automatic model_update(input pc_t pc, input ftb_info_t info);
        ftb_index_t idx;
        int         way;
        idx = pc[5:1];
        model_find(pc, way);
        if (way < 0 && ref_cnt[idx] < FTB_WAYS) begin
            way = ref_cnt[idx];
            ref_cnt[idx]++;
        end
        if (way >= 0) begin
            ref_pc[idx][way]   = pc;
            ref_info[idx][way] = info;
        end
    endtask

    task automatic model_replace(input pc_t old_pc, input pc_t pc, input ftb_info_t info);
        int way;
        model_find(old_pc, way);
        if (way >= 0) begin
            ref_pc[pc[5:1]][way]   = pc;
            ref_info[pc[5:1]][way] = info;
        end
    endtask

    task automatic compare_resp(input pc_t pc);
        int way;
        model_find(pc, way);
        check_bit("o_resp.hit", way >= 0, o_resp.hit);
        if (way >= 0) check_info("o_resp.info", ref_info[pc[5:1]][way], o_resp.info);
    endtask

    // returns at the negedge where the response is held
    task automatic run_lookup(input pc_t pc);
        @(negedge clk);
        i_lookup_vld = 1'b1;
        i_lookup.pc  = pc;
        #1;
        check_bit("o_lookup_gnt", 1'b1, o_lookup_gnt);
        @(negedge clk);
        i_lookup_vld = 1'b0;
        check_bit("o_resp_vld", 1'b0, o_resp_vld);
        @(negedge clk);
        check_bit("o_resp_vld", 1'b1, o_resp_vld);
    endtask

    task automatic lookup_pair(input pc_t pc_a, input pc_t pc_b);
        @(negedge clk);
        i_lookup_vld = 1'b1;
        i_lookup.pc  = pc_a;
        #1;
        check_bit("o_lookup_gnt", 1'b1, o_lookup_gnt);
        @(negedge clk);
        i_lookup.pc = pc_b;
        #1;
        check_bit("o_lookup_gnt", 1'b1, o_lookup_gnt);
        check_bit("o_resp_vld", 1'b0, o_resp_vld);
        @(negedge clk);
        i_lookup_vld = 1'b0;
        check_bit("o_resp_vld", 1'b1, o_resp_vld);
        compare_resp(pc_a);
        @(negedge clk);
        check_bit("o_resp_vld", 1'b1, o_resp_vld);
        compare_resp(pc_b);
    endtask

    // write lands at the end of the second cycle
    task automatic do_update(input pc_t pc, input ftb_info_t info);
        @(negedge clk);
        i_update_vld  = 1'b1;
        i_update.pc   = pc;
        i_update.info = info;
        @(negedge clk);
        i_update_vld = 1'b0;
        model_update(pc, info);
    endtask

    task automatic test_cold_miss();
        logic [31:0] t;
        for (int i = 0; i < 8; i++) begin
            rand_bits(32, t);
            run_lookup(t);
            compare_resp(t);
        end
    endtask

    task automatic test_fill_hit();
        logic [31:0] t;
        ftb_tag_t    tag;
        rand_bits(5, t);
        fill_set = t[4:0];
        for (int i = 0; i < 4; i++) begin
            new_tag(i, tag);
            rand_pc(fill_set, tag, set_pcs[i]);
            rand_info(set_infos[i]);
            do_update(set_pcs[i], set_infos[i]);
            run_lookup(set_pcs[i]);
            compare_resp(set_pcs[i]);
        end
        lookup_pair(set_pcs[0], set_pcs[1]);
        lookup_pair(set_pcs[3], set_pcs[2]);
    endtask

    task automatic test_rewrite();
        // same tag, other upper pc bits
        rand_pc(fill_set, set_pcs[1][21:6], set_pcs[1]);
        rand_info(set_infos[1]);
        do_update(set_pcs[1], set_infos[1]);
        run_lookup(set_pcs[1]);
        compare_resp(set_pcs[1]);
        for (int j = 0; j < 4; j++) begin
            if (j != 1) begin
                run_lookup(set_pcs[j]);
                compare_resp(set_pcs[j]);
            end
        end
    endtask

    task automatic test_evict();
        ftb_tag_t tag;
        int       hits;
        int       missed;
        new_tag(4, tag);
        rand_pc(fill_set, tag, set_pcs[4]);
        rand_info(set_infos[4]);
        do_update(set_pcs[4], set_infos[4]);
        run_lookup(set_pcs[4]);
        check_bit("o_resp.hit", 1'b1, o_resp.hit);
        check_info("o_resp.info", set_infos[4], o_resp.info);
        hits   = 0;
        missed = -1;
        for (int j = 0; j < 4; j++) begin
            run_lookup(set_pcs[j]);
            if (o_resp.hit) begin
                hits++;
                compare_resp(set_pcs[j]);
            end else begin
                missed = j;
            end
        end
        assert (hits == 3) else begin
            value_errs++;
            $display("[ERROR] %0t o_resp.hit count exp 4 got %0d", $time, hits + 1);
        end
        if (missed >= 0) model_replace(set_pcs[missed], set_pcs[4], set_infos[4]);
    endtask

    task automatic test_squash_arb();
        logic [31:0] t;
        ftb_index_t  idx;
        pc_t         upd_pc;
        ftb_info_t   upd_info;
        // squash in s0
        @(negedge clk);
        i_lookup_vld = 1'b1;
        i_lookup.pc  = set_pcs[4];
        i_squash     = 1'b1;
        #1;
        check_bit("o_lookup_gnt", 1'b1, o_lookup_gnt);
        @(negedge clk);
        i_lookup_vld = 1'b0;
        i_squash     = 1'b0;
        check_bit("o_resp_vld", 1'b0, o_resp_vld);
        @(negedge clk);
        check_bit("o_resp_vld", 1'b0, o_resp_vld);
        // update and lookup collide, update wins
        idx = fill_set + 5'd1;
        rand_bits(16, t);
        rand_pc(idx, t[15:0], upd_pc);
        rand_info(upd_info);
        @(negedge clk);
        i_update_vld  = 1'b1;
        i_update.pc   = upd_pc;
        i_update.info = upd_info;
        i_lookup_vld  = 1'b1;
        i_lookup.pc   = set_pcs[4];
        #1;
        check_bit("o_lookup_gnt", 1'b0, o_lookup_gnt);
        @(negedge clk);
        i_update_vld = 1'b0;
        #1;
        check_bit("o_lookup_gnt", 1'b1, o_lookup_gnt);
        check_bit("o_resp_vld", 1'b0, o_resp_vld);
        @(negedge clk);
        i_lookup_vld = 1'b0;
        check_bit("o_resp_vld", 1'b0, o_resp_vld);
        @(negedge clk);
        check_bit("o_resp_vld", 1'b1, o_resp_vld);
        compare_resp(set_pcs[4]);
        model_update(upd_pc, upd_info);
        run_lookup(upd_pc);
        compare_resp(upd_pc);
    endtask

    initial begin
        rst          = 1'b1;
        i_squash     = 1'b0;
        i_lookup_vld = 1'b0;
        i_lookup     = '0;
        i_update_vld = 1'b0;
        i_update     = '0;
        lfsr_q       = LFSR_SEED;
        value_errs   = 0;
        other_errs   = 0;
        for (int s = 0; s < FTB_SETS; s++) begin
            ref_cnt[s] = 0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_cold_miss();
        test_fill_hit();
        test_rewrite();
        test_evict();
        test_squash_arb();

        repeat (4) @(negedge clk);
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- src/ftb_pkg.sv
package ftb_pkg;

    // table geometry
    localparam int FTB_SETS    = 32;
    localparam int FTB_WAYS    = 4;
    localparam int FTB_WAY_W   = 2;
    localparam int FTB_INDEX_W = 5;
    localparam int FTB_TAG_W   = 16;
    localparam int XLEN        = 32;

    // pc bit positions, bit 0 dropped for 2-byte fetch alignment
    localparam int FTB_INDEX_LSB = 1;
    localparam int FTB_TAG_LSB   = FTB_INDEX_LSB + FTB_INDEX_W;

    // replacement lfsr
    localparam int              REP_LFSR_W    = 16;
    localparam [REP_LFSR_W-1:0] REP_LFSR_SEED = 16'hace1;

    typedef logic [XLEN-1:0]        pc_t;
    typedef logic [FTB_INDEX_W-1:0] ftb_index_t;
    typedef logic [FTB_TAG_W-1:0]   ftb_tag_t;
    typedef logic [FTB_WAYS-1:0]    way_vec_t;
    typedef logic [FTB_WAY_W-1:0]   way_idx_t;
    typedef logic [1:0]             br_type_t;
    typedef logic [3:0]             fall_off_t;

    typedef struct packed {
        pc_t       target_pc;
        br_type_t  br_type;
        fall_off_t fall_offset;
    } ftb_info_t;

    typedef struct packed {
        ftb_tag_t  tag;
        logic      vld;
        ftb_info_t info;
    } ftb_entry_t;

    typedef struct packed {
        pc_t pc;
    } ftb_lookup_req_t;

    typedef struct packed {
        logic      hit;
        ftb_info_t info;
    } ftb_lookup_resp_t;

    typedef struct packed {
        pc_t       pc;
        ftb_info_t info;
    } ftb_update_req_t;

    typedef enum logic {
        UPD_IDLE,
        UPD_WRITE
    } upd_state_t;

    function automatic ftb_index_t pc_index(pc_t pc);
        return pc[FTB_TAG_LSB-1:FTB_INDEX_LSB];
    endfunction

    function automatic ftb_tag_t pc_tag(pc_t pc);
        return pc[FTB_TAG_LSB+FTB_TAG_W-1:FTB_TAG_LSB];
    endfunction

endpackage

//--- src/ftb_random_rep.sv
`timescale 1ns/1ps

module ftb_random_rep
    import ftb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output way_vec_t o_replace_vec
);

    logic [REP_LFSR_W-1:0] lfsr_q;
    logic                  feedback;
    way_idx_t              victim;

    // taps 16,14,13,11
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= REP_LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[REP_LFSR_W-2:0], feedback};
        end
    end

    // low bits pick the victim
    assign victim = lfsr_q[FTB_WAY_W-1:0];

    always_comb begin
        o_replace_vec = '0;
        o_replace_vec[victim] = 1'b1;
    end

endmodule

//--- src/ftb_sram.sv
`timescale 1ns/1ps

module ftb_sram
    import ftb_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_squash,

    // read select from the controller
    input  logic                       i_rd_vld,
    input  pc_t                        i_rd_pc,
    input  logic                       i_rd_is_update,

    // write command from the controller
    input  logic                       i_wr_vld,
    input  way_vec_t                   i_wr_way_vec,
    input  pc_t                        i_wr_pc,
    input  ftb_info_t                  i_wr_info,

    output way_vec_t                   o_sel_vec,
    output logic                       o_resp_vld,
    output ftb_lookup_resp_t           o_resp,

    // array side
    output logic                       o_rd_en,
    output ftb_index_t                 o_rd_index,
    input  ftb_entry_t [FTB_WAYS-1:0]  i_rd_data,
    output ftb_index_t                 o_wr_index,
    output way_vec_t                   o_wr_way_vec,
    output ftb_entry_t                 o_wr_entry,

    input  way_vec_t                   i_replace_vec
);

    logic      s1_rd_vld_q;
    logic      s1_is_lookup_q;
    pc_t       s1_pc_q;
    ftb_tag_t  s1_tag;

    way_vec_t  s1_hit_vec;
    way_vec_t  s1_inv_vec;
    way_vec_t  s1_first_inv;
    ftb_info_t s1_hit_info;

    logic             s2_vld_q;
    ftb_lookup_resp_t s2_resp_q;

    // s0
    assign o_rd_en    = i_rd_vld;
    assign o_rd_index = pc_index(i_rd_pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_rd_vld_q    <= 1'b0;
            s1_is_lookup_q <= 1'b0;
        end else begin
            s1_rd_vld_q    <= i_rd_vld;
            // squash in s0 drops the lookup here
            s1_is_lookup_q <= i_rd_vld && !i_rd_is_update && !i_squash;
        end
    end

    always_ff @(posedge clk) begin
        s1_pc_q <= i_rd_pc;
    end

    // s1 tag compare
    assign s1_tag = pc_tag(s1_pc_q);

    always_comb begin
        s1_hit_info = '0;
        for (int w = 0; w < FTB_WAYS; w++) begin
            s1_hit_vec[w] = s1_rd_vld_q && i_rd_data[w].vld && (i_rd_data[w].tag == s1_tag);
            s1_inv_vec[w] = !i_rd_data[w].vld;
            if (s1_hit_vec[w]) begin
                s1_hit_info = s1_hit_info | i_rd_data[w].info;
            end
        end
    end

    // isolate lowest set bit
    assign s1_first_inv = s1_inv_vec & (~s1_inv_vec + way_vec_t'(1));

    always_comb begin
        if (|s1_hit_vec) begin
            o_sel_vec = s1_hit_vec;
        end else if (|s1_inv_vec) begin
            o_sel_vec = s1_first_inv;
        end else begin
            o_sel_vec = i_replace_vec;
        end
    end

    // s2 response
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_vld_q <= 1'b0;
        end else begin
            s2_vld_q <= s1_is_lookup_q && !i_squash;
        end
    end

    always_ff @(posedge clk) begin
        s2_resp_q.hit  <= |s1_hit_vec;
        s2_resp_q.info <= s1_hit_info;
    end

    assign o_resp_vld = s2_vld_q;
    assign o_resp     = s2_resp_q;

    // write entry
    assign o_wr_index   = pc_index(i_wr_pc);
    assign o_wr_way_vec = i_wr_vld ? i_wr_way_vec : '0;
    assign o_wr_entry   = '{tag: pc_tag(i_wr_pc), vld: 1'b1, info: i_wr_info};

endmodule

//--- src/ftb_sram_set.sv
`timescale 1ns/1ps

module ftb_sram_set
    import ftb_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       i_rd_en,
    input  ftb_index_t                 i_rd_index,
    output ftb_entry_t [FTB_WAYS-1:0]  o_rd_data,

    input  ftb_index_t                 i_wr_index,
    input  way_vec_t                   i_wr_way_vec,
    input  ftb_entry_t                 i_wr_entry
);

    ftb_entry_t mem [FTB_SETS][FTB_WAYS];
    ftb_entry_t [FTB_WAYS-1:0] rd_q;

    // valid bits per set
    way_vec_t set_vld_q [FTB_SETS];
    way_vec_t rd_vld_q;

    // registered read returns old data on a same-set write
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            for (int w = 0; w < FTB_WAYS; w++) begin
                rd_q[w] <= mem[i_rd_index][w];
            end
        end
        for (int w = 0; w < FTB_WAYS; w++) begin
            if (i_wr_way_vec[w]) begin
                mem[i_wr_index][w] <= i_wr_entry;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < FTB_SETS; s++) begin
                set_vld_q[s] <= '0;
            end
            rd_vld_q <= '0;
        end else begin
            if (i_rd_en) begin
                rd_vld_q <= set_vld_q[i_rd_index];
            end
            for (int w = 0; w < FTB_WAYS; w++) begin
                if (i_wr_way_vec[w]) begin
                    set_vld_q[i_wr_index][w] <= i_wr_entry.vld;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < FTB_WAYS; w++) begin
            o_rd_data[w]     = rd_q[w];
            o_rd_data[w].vld = rd_vld_q[w];
        end
    end

endmodule

//--- src/ftb_top.sv
`timescale 1ns/1ps

module ftb_top
    import ftb_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             i_squash,

    input  logic             i_lookup_vld,
    input  ftb_lookup_req_t  i_lookup,
    output logic             o_lookup_gnt,
    output logic             o_resp_vld,
    output ftb_lookup_resp_t o_resp,

    input  logic             i_update_vld,
    input  ftb_update_req_t  i_update
);

    // controller to pipeline
    logic      rd_vld;
    pc_t       rd_pc;
    logic      rd_is_update;
    way_vec_t  sel_vec;
    logic      wr_vld;
    way_vec_t  wr_way_vec;
    pc_t       wr_pc;
    ftb_info_t wr_info;

    // pipeline to array
    logic                      arr_rd_en;
    ftb_index_t                arr_rd_index;
    ftb_entry_t [FTB_WAYS-1:0] arr_rd_data;
    ftb_index_t                arr_wr_index;
    way_vec_t                  arr_wr_way_vec;
    ftb_entry_t                arr_wr_entry;

    way_vec_t replace_vec;

    ftb_update_ctrl u_update_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_update_vld   (i_update_vld),
        .i_update       (i_update),
        .i_lookup_vld   (i_lookup_vld),
        .i_lookup       (i_lookup),
        .o_lookup_gnt   (o_lookup_gnt),
        .o_rd_vld       (rd_vld),
        .o_rd_pc        (rd_pc),
        .o_rd_is_update (rd_is_update),
        .i_sel_vec      (sel_vec),
        .o_wr_vld       (wr_vld),
        .o_wr_way_vec   (wr_way_vec),
        .o_wr_pc        (wr_pc),
        .o_wr_info      (wr_info)
    );

    ftb_sram u_sram (
        .clk            (clk),
        .rst            (rst),
        .i_squash       (i_squash),
        .i_rd_vld       (rd_vld),
        .i_rd_pc        (rd_pc),
        .i_rd_is_update (rd_is_update),
        .i_wr_vld       (wr_vld),
        .i_wr_way_vec   (wr_way_vec),
        .i_wr_pc        (wr_pc),
        .i_wr_info      (wr_info),
        .o_sel_vec      (sel_vec),
        .o_resp_vld     (o_resp_vld),
        .o_resp         (o_resp),
        .o_rd_en        (arr_rd_en),
        .o_rd_index     (arr_rd_index),
        .i_rd_data      (arr_rd_data),
        .o_wr_index     (arr_wr_index),
        .o_wr_way_vec   (arr_wr_way_vec),
        .o_wr_entry     (arr_wr_entry),
        .i_replace_vec  (replace_vec)
    );

    ftb_sram_set u_sram_set (
        .clk          (clk),
        .rst          (rst),
        .i_rd_en      (arr_rd_en),
        .i_rd_index   (arr_rd_index),
        .o_rd_data    (arr_rd_data),
        .i_wr_index   (arr_wr_index),
        .i_wr_way_vec (arr_wr_way_vec),
        .i_wr_entry   (arr_wr_entry)
    );

    ftb_random_rep u_random_rep (
        .clk           (clk),
        .rst           (rst),
        .o_replace_vec (replace_vec)
    );

endmodule

//--- src/ftb_update_ctrl.sv
`timescale 1ns/1ps

module ftb_update_ctrl
    import ftb_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            i_update_vld,
    input  ftb_update_req_t i_update,

    input  logic            i_lookup_vld,
    input  ftb_lookup_req_t i_lookup,
    output logic            o_lookup_gnt,

    output logic            o_rd_vld,
    output pc_t             o_rd_pc,
    output logic            o_rd_is_update,

    input  way_vec_t        i_sel_vec,

    output logic            o_wr_vld,
    output way_vec_t        o_wr_way_vec,
    output pc_t             o_wr_pc,
    output ftb_info_t       o_wr_info
);

    upd_state_t state_q;
    upd_state_t state_d;
    logic       upd_rd;
    pc_t        pc_q;
    ftb_info_t  info_q;

    // strobe dropped while writing
    assign upd_rd = (state_q == UPD_IDLE) && i_update_vld;

    always_comb begin
        state_d = state_q;
        case (state_q)
            UPD_IDLE:  if (upd_rd) state_d = UPD_WRITE;
            UPD_WRITE: state_d = UPD_IDLE;
            default:   state_d = UPD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= UPD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_rd) begin
            pc_q   <= i_update.pc;
            info_q <= i_update.info;
        end
    end

    // update read wins over lookup
    assign o_lookup_gnt   = i_lookup_vld && !upd_rd;
    assign o_rd_vld       = upd_rd || o_lookup_gnt;
    assign o_rd_pc        = upd_rd ? i_update.pc : i_lookup.pc;
    assign o_rd_is_update = upd_rd;

    assign o_wr_vld     = (state_q == UPD_WRITE);
    assign o_wr_way_vec = i_sel_vec;
    assign o_wr_pc      = pc_q;
    assign o_wr_info    = info_q;

endmodule
